/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int x_w          = 11;     // covers widths up to 2048
    localparam int y_w          = 10;     // covers heights up to 1024
    localparam int gray_latency = 4;      // pixel_in to pixel_out in clocks

    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        logic [7:0]     r;
        logic [7:0]     g;
        logic [7:0]     b;
        logic [x_w-1:0] x;
        logic [y_w-1:0] y;
    } pixel_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone classic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] reg_ctrl   = 4'h0;  // bit 0 is gray_en
    localparam logic [3:0] reg_frames = 4'h4;  // read only frame count

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;                 // byte address
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage : video_pkg

`default_nettype wire

/* hdl/pixel_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_delay #(
    parameter int  delay     = 1,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    payload_t stages [delay];             // stages[0] is the newest entry

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < delay; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < delay; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[delay-1];

    // once reset has run, every stage holds defined data, so an X here came in through d
    q_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(q)
    ) else $error("pixel_delay output is unknown");

endmodule : pixel_delay

`default_nettype wire

/* hdl/gray_convert.sv */
`timescale 1ns/1ps
`default_nettype none

module gray_convert #(
    parameter int h_act = 1280,
    parameter int v_act = 720
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              gray_en,
    input  video_pkg::pixel_t pixel_in,
    output video_pkg::pixel_t pixel_out
);

    logic [14:0]       prod_r;
    logic [14:0]       prod_g;
    logic [14:0]       prod_b;
    logic [14:0]       luma_sum;
    logic [7:0]        gray_s3;
    logic [7:0]        gray_s4;
    logic              en_s4;
    video_pkg::pixel_t bypass;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // luma = (38*r + 75*g + 15*b) >> 7
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_r   <= '0;
            prod_g   <= '0;
            prod_b   <= '0;
            luma_sum <= '0;
            gray_s3  <= '0;
            en_s4    <= 1'b0;
        end else begin
            prod_r   <= 15'(pixel_in.r) * 15'd38;      // stage 1
            prod_g   <= 15'(pixel_in.g) * 15'd75;
            prod_b   <= 15'(pixel_in.b) * 15'd15;
            luma_sum <= prod_r + prod_g + prod_b;      // stage 2, max 32640 fits
            gray_s3  <= luma_sum[14:7];                // stage 3
            en_s4    <= gray_en;                       // sampled as the pixel enters stage 4
        end
    end

    pixel_delay #(
        .delay    (1),
        .payload_t(logic [7:0])
    ) u_gray_reg (
        .clk  (clk),
        .reset(reset),
        .d    (gray_s3),
        .q    (gray_s4)
    );

    // sync, de and coordinates ride alongside the colour math
    pixel_delay #(
        .delay    (video_pkg::gray_latency),
        .payload_t(video_pkg::pixel_t)
    ) u_bypass (
        .clk  (clk),
        .reset(reset),
        .d    (pixel_in),
        .q    (bypass)
    );

    always_comb begin
        pixel_out = bypass;
        if (en_s4) begin
            pixel_out.r = gray_s4;
            pixel_out.g = gray_s4;
            pixel_out.b = gray_s4;
        end
    end

    x_in_range: assert property (
        @(posedge clk) disable iff (reset)
        pixel_in.de |-> (pixel_in.x < h_act)
    ) else $error("active pixel x %0d outside h_act", pixel_in.x);

    y_in_range: assert property (
        @(posedge clk) disable iff (reset)
        pixel_in.de |-> (pixel_in.y < v_act)
    ) else $error("active pixel y %0d outside v_act", pixel_in.y);

endmodule : gray_convert

`default_nettype wire

/* hdl/video_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module video_regs (
    input  logic               clk,
    input  logic               reset,
    input  video_pkg::wb_req_t wb_req,
    output video_pkg::wb_rsp_t wb_rsp,
    input  video_pkg::pixel_t  pixel_out,
    output logic               gray_en
);

    logic        ack;
    logic [31:0] rd_dat;
    logic        req;
    logic        vsync_q;
    logic [15:0] frame_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign req = wb_req.cyc && wb_req.stb && !ack;   // skip the cycle right after an ack

    always_ff @(posedge clk) begin
        if (reset) begin
            ack     <= 1'b0;
            rd_dat  <= '0;
            gray_en <= 1'b0;
        end else begin
            ack <= req;
            if (req) begin
                rd_dat <= '0;                        // unmapped addresses read zero
                if (wb_req.we) begin
                    if (wb_req.adr == video_pkg::reg_ctrl) begin
                        gray_en <= wb_req.dat[0];    // writes to reg_frames fall through
                    end
                end else begin
                    case (wb_req.adr)
                        video_pkg::reg_ctrl:   rd_dat <= {31'd0, gray_en};
                        video_pkg::reg_frames: rd_dat <= {16'd0, frame_cnt};
                        default:               rd_dat <= '0;
                    endcase
                end
            end
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame counter on the outgoing stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vsync_q <= pixel_out.vsync;
            if (pixel_out.vsync && !vsync_q) begin
                frame_cnt <= frame_cnt + 16'd1;      // wraps at 65535
            end
        end
    end

    ack_single: assert property (
        @(posedge clk) disable iff (reset)
        ack |=> !ack
    ) else $error("wishbone ack held for two cycles");

    ack_after_req: assert property (
        @(posedge clk) disable iff (reset)
        ack |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("wishbone ack without a preceding request");

endmodule : video_regs

`default_nettype wire

/* hdl/video_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_pipe_top #(
    parameter int h_act = 1280,
    parameter int v_act = 720
) (
    input  logic               clk,
    input  logic               reset,
    input  video_pkg::pixel_t  pixel_in,
    output video_pkg::pixel_t  pixel_out,
    input  video_pkg::wb_req_t wb_req,
    output video_pkg::wb_rsp_t wb_rsp
);

    logic gray_en;                        // control bit from the register block

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    gray_convert #(
        .h_act(h_act),
        .v_act(v_act)
    ) u_gray_convert (
        .clk      (clk),
        .reset    (reset),
        .gray_en  (gray_en),
        .pixel_in (pixel_in),
        .pixel_out(pixel_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    video_regs u_video_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .pixel_out(pixel_out),            // frames are counted as they leave
        .gray_en  (gray_en)
    );

endmodule : video_pipe_top

`default_nettype wire

/* test/video_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module video_pipe_tb;

    localparam int h_act = 1280;
    localparam int v_act = 720;

    logic               clk;
    logic               reset;
    video_pkg::pixel_t  pixel_in;
    video_pkg::pixel_t  pixel_out;
    video_pkg::wb_req_t wb_req;
    video_pkg::wb_rsp_t wb_rsp;

    video_pkg::pixel_t  expect_q[$];      // one entry per pixel still inside the pipeline
    logic               model_gray_en;
    int                 seed;
    int                 checks;
    int                 pixel_errors;
    int                 bus_errors;
    int                 other_errors;
    int                 cycle_count;
    int                 cycle_limit = 200;

    video_pipe_top uut (
        .clk      (clk),
        .reset    (reset),
        .pixel_in (pixel_in),
        .pixel_out(pixel_out),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: simulation timed out after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] luma(input int r, input int g, input int b);
        int sum;
        sum = 38 * r + 75 * g + 15 * b;   // weights add up to 128
        return 8'(sum >> 7);
    endfunction

    function automatic video_pkg::pixel_t predict_pixel(input video_pkg::pixel_t pix,
                                                        input logic en);
        video_pkg::pixel_t res;
        res = pix;
        if (en) begin
            res.r = luma(pix.r, pix.g, pix.b);
            res.g = res.r;
            res.b = res.r;
        end
        return res;
    endfunction

    function automatic string diff_fields(input video_pkg::pixel_t got,
                                          input video_pkg::pixel_t exp);
        string s;
        s = "";
        if (got.hsync !== exp.hsync) s = {s, " hsync"};
        if (got.vsync !== exp.vsync) s = {s, " vsync"};
        if (got.de !== exp.de) s = {s, " de"};
        if (got.r !== exp.r) s = {s, " r"};
        if (got.g !== exp.g) s = {s, " g"};
        if (got.b !== exp.b) s = {s, " b"};
        if (got.x !== exp.x) s = {s, " x"};
        if (got.y !== exp.y) s = {s, " y"};
        return s;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic step_cycle(input video_pkg::pixel_t pix);
        video_pkg::pixel_t exp_pix;
        @(negedge clk);
        exp_pix = expect_q.pop_front();   // driven gray_latency falling edges ago
        checks++;
        assert (pixel_out === exp_pix) else begin
            pixel_errors++;
            $display("CHECK FAILED at %0t: pixel_out field%s got %h expected %h",
                     $time, diff_fields(pixel_out, exp_pix), pixel_out, exp_pix);
        end
        pixel_in = pix;
        expect_q.push_back(predict_pixel(pix, model_gray_en));
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdata);
        int waited;
        bit acked;
        waited = 0;
        acked  = 1'b0;
        rdata  = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        while (!acked && waited < 16) begin
            step_cycle('0);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdata = wb_rsp.dat;
            end
        end
        wb_req = '0;
        if (!acked) begin
            bus_errors++;
            $display("ERROR: no wishbone ack at %0t for address %h", $time, adr);
        end else begin
            checks++;
            assert (waited == 1) else begin
                bus_errors++;
                $display("CHECK FAILED at %0t: ack after %0d cycles, expected 1", $time, waited);
            end
            if (we && adr == video_pkg::reg_ctrl) model_gray_en = dat[0];
        end
        step_cycle('0);                   // bus idles one cycle between accesses
    endtask

    task automatic run_cases(input int fd);
        string             line;
        byte               op;
        int                a;
        int                b;
        int                c;
        int                r;
        int                g;
        int                bl;
        int                x;
        int                y;
        logic [31:0]       rdata;
        video_pkg::pixel_t pix;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            op = line[0];
            pix = '0;
            case (op)
                "W": begin
                    void'($sscanf(line, "W %h %h", a, b));
                    bus_access(1'b1, a[3:0], b, rdata);
                end
                "R": begin
                    void'($sscanf(line, "R %h %h", a, b));
                    bus_access(1'b0, a[3:0], '0, rdata);
                    checks++;
                    assert (rdata === b) else begin
                        bus_errors++;
                        $display("CHECK FAILED at %0t: read of %h got %h expected %h",
                                 $time, a[3:0], rdata, b);
                    end
                end
                "P": begin
                    void'($sscanf(line, "P %d %d %d %h %h %h %d %d", a, b, c, r, g, bl, x, y));
                    pix = '{hsync: a[0], vsync: b[0], de: c[0], r: r[7:0], g: g[7:0],
                            b: bl[7:0], x: x[10:0], y: y[9:0]};
                    step_cycle(pix);
                end
                "N": begin
                    void'($sscanf(line, "N %d", a));
                    repeat (a) begin
                        x = $unsigned($random(seed)) % h_act;   // keeps the range checks quiet
                        y = $unsigned($random(seed)) % v_act;
                        pix.de = 1'b1;
                        pix.r  = $random(seed);
                        pix.g  = $random(seed);
                        pix.b  = $random(seed);
                        pix.x  = x[10:0];
                        pix.y  = y[9:0];
                        step_cycle(pix);
                    end
                end
                "I": begin
                    void'($sscanf(line, "I %d", a));
                    repeat (a) step_cycle('0);
                end
                default: begin
                    other_errors++;
                    $display("ERROR: unknown operation in cases line: %s", line);
                end
            endcase
        end
    endtask

    initial begin
        int    fd;
        int    n_lines;
        string line;
        clk           = 1'b0;
        reset         = 1'b1;
        pixel_in      = '0;
        wb_req        = '0;
        model_gray_en = 1'b0;
        seed          = 99;
        n_lines       = 0;
        fd = $fopen("test/video_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: cannot open test/video_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) n_lines++;
            $fclose(fd);
            cycle_limit = n_lines * 20 + 200;
            repeat (8) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            repeat (video_pkg::gray_latency) expect_q.push_back('0);  // pipeline cleared by reset
            fd = $fopen("test/video_cases.txt", "r");
            run_cases(fd);
            $fclose(fd);
        end
        $display("errors: %0d pixel, %0d bus, %0d other over %0d checks",
                 pixel_errors, bus_errors, other_errors, checks);
        if (pixel_errors + bus_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : video_pipe_tb

`default_nettype wire

/* project.f */
hdl/video_pkg.sv
hdl/pixel_delay.sv
hdl/gray_convert.sv
hdl/video_regs.sv
hdl/video_pipe_top.sv
test/video_pipe_tb.sv

/* test/video_cases.txt */
# W adr dat | R adr expected | P hsync vsync de r g b x y | N pixels | I idle cycles
# adr, dat, expected, r, g and b are hex; sync flags, x, y and counts are decimal
I 2
R 0 0
R 4 0
P 0 0 1 12 34 56 0 0
P 0 0 1 ff ff ff 1 0
P 0 0 1 00 00 00 2 0
P 1 0 0 80 40 20 3 0
P 0 0 1 a5 5a c3 1279 719
P 1 0 0 01 02 03 0 1
N 16
I 8
W 0 1
R 0 1
P 0 0 1 ff ff ff 10 5
P 0 0 1 00 00 00 11 5
P 0 0 1 ff 00 00 12 5
P 0 0 1 00 ff 00 13 5
P 0 0 1 00 00 ff 14 5
P 1 0 0 aa 55 33 15 5
P 0 0 1 7f 80 81 1279 719
N 20
I 8
W 0 0
R 0 0
P 0 0 1 ff 00 00 20 6
P 0 0 1 10 20 30 21 6
N 8
I 8
P 0 1 0 00 00 00 0 0
P 0 1 0 00 00 00 0 0
I 3
P 0 1 0 00 00 00 0 0
I 3
P 0 1 0 00 00 00 0 0
I 8
R 4 3
W 4 ff
R 4 3
R 8 0
R c 0
I 4
